//--- verilog/mini_core_pkg.sv
package mini_core_pkg;

    // basic data types
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam int NUM_REGS = 32;

    // MIPS32 primary opcodes
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_LUI     = 6'h0f;

    // SPECIAL function codes
    localparam logic [5:0] FN_MFHI  = 6'h10;
    localparam logic [5:0] FN_MFLO  = 6'h12;
    localparam logic [5:0] FN_MULTU = 6'h19;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR   = 6'h26;
    localparam logic [5:0] FN_SLT   = 6'h2a;

    // busy cycles spent by one multiply
    localparam int MUL_CYCLES = 4;
    localparam int MUL_CNT_W  = $clog2(MUL_CYCLES + 1);

    // operations carried down the pipe
    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADDU,
        OP_SUBU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_ADDIU,
        OP_LUI,
        OP_MULTU,
        OP_MFHI,
        OP_MFLO
    } op_t;

    // multiplier sequencing
    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_BUSY,
        MUL_DONE
    } mul_state_t;

endpackage

//--- verilog/fwd_if.sv
`timescale 1ns/1ns

interface fwd_if import mini_core_pkg::*; ();

    // destination register of the stage
    reg_addr_t rdst;
    // stage writes rdst, already cleared for register 0
    logic      regwrite;
    // value headed for rdst
    word_t     data;
    // stage holds a real instruction
    logic      valid;

    modport src (
        output rdst, regwrite, data, valid
    );

    modport dst (
        input rdst, regwrite, data, valid
    );

endinterface

//--- verilog/regfile.sv
`timescale 1ns/1ns

module regfile import mini_core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t ra1,
    input  reg_addr_t ra2,
    input  reg_addr_t wa,
    input  logic      we,
    input  word_t     wd,
    output word_t     rd1,
    output word_t     rd2
);

    word_t regs [NUM_REGS];

    // register 0 never takes a write
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    // asynchronous read, same-cycle writes come through forwarding
    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

endmodule

//--- verilog/inst_decode.sv
`timescale 1ns/1ns

module inst_decode import mini_core_pkg::*; (
    input  word_t     instr,
    output op_t       op,
    output reg_addr_t ra1,
    output reg_addr_t ra2,
    output reg_addr_t rdst,
    output logic      regwrite,
    output word_t     imm
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    // rs and rt are always read, unused reads are harmless
    assign ra1 = instr[25:21];
    assign ra2 = instr[20:16];

    always_comb begin
        op       = OP_NOP;
        rdst     = instr[15:11];
        regwrite = 1'b0;
        imm      = {{16{instr[15]}}, instr[15:0]};
        case (opcode)
            OPC_SPECIAL: begin
                case (funct)
                    FN_ADDU:  op = OP_ADDU;
                    FN_SUBU:  op = OP_SUBU;
                    FN_AND:   op = OP_AND;
                    FN_OR:    op = OP_OR;
                    FN_XOR:   op = OP_XOR;
                    FN_SLT:   op = OP_SLT;
                    FN_MULTU: op = OP_MULTU;
                    FN_MFHI:  op = OP_MFHI;
                    FN_MFLO:  op = OP_MFLO;
                    default:  op = OP_NOP;
                endcase
                // multu only updates hi/lo
                regwrite = (op != OP_NOP) && (op != OP_MULTU);
            end
            OPC_ADDIU: begin
                op       = OP_ADDIU;
                rdst     = instr[20:16];
                regwrite = 1'b1;
            end
            OPC_LUI: begin
                op       = OP_LUI;
                rdst     = instr[20:16];
                regwrite = 1'b1;
                imm      = {instr[15:0], 16'h0000};
            end
            default: begin
                op       = OP_NOP;
                regwrite = 1'b0;
            end
        endcase
    end

endmodule

//--- verilog/fwd_hazard.sv
`timescale 1ns/1ns

module fwd_hazard import mini_core_pkg::*; (
    input  reg_addr_t ra1,
    input  reg_addr_t ra2,
    input  word_t     rd1,
    input  word_t     rd2,
    fwd_if.dst        fwd_e,
    fwd_if.dst        fwd_w,
    input  logic      mul_busy,
    output word_t     srca,
    output word_t     srcb,
    output logic      stall
);

    // youngest producer wins: E, then W, then the file
    function automatic word_t select_src(
        input reg_addr_t ra,
        input word_t     file_data
    );
        word_t result;
        result = file_data;
        if (ra == '0) begin
            result = '0;
        end else if (fwd_e.valid && fwd_e.regwrite && (fwd_e.rdst == ra)) begin
            result = fwd_e.data;
        end else if (fwd_w.valid && fwd_w.regwrite && (fwd_w.rdst == ra)) begin
            result = fwd_w.data;
        end
        return result;
    endfunction

    always_comb begin
        srca = select_src(ra1, rd1);
        srcb = select_src(ra2, rd2);
    end

    // only structural hazard is the multiplier
    // data hazards are all covered by forwarding
    assign stall = mul_busy;

endmodule

//--- verilog/mul_fsm.sv
`timescale 1ns/1ns

module mul_fsm import mini_core_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  start,
    input  word_t a,
    input  word_t b,
    output logic  busy,
    output word_t hi,
    output word_t lo
);

    mul_state_t           state;
    mul_state_t           state_next;
    logic [MUL_CNT_W-1:0] count;
    word_t                a_q;
    word_t                b_q;
    logic [63:0]          product;

    // start only counts in idle, a multu still sitting in E during DONE is ignored
    assign busy = (state == MUL_BUSY) || ((state == MUL_IDLE) && start);

    // unsigned 64-bit product of the latched operands
    assign product = 64'(a_q) * 64'(b_q);

    always_comb begin
        state_next = state;
        case (state)
            MUL_IDLE: begin
                if (start) begin
                    state_next = MUL_BUSY;
                end
            end
            MUL_BUSY: begin
                if (count == MUL_CNT_W'(MUL_CYCLES - 1)) begin
                    state_next = MUL_DONE;
                end
            end
            MUL_DONE: begin
                state_next = MUL_IDLE;
            end
            default: begin
                state_next = MUL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= MUL_IDLE;
            count <= '0;
        end else begin
            state <= state_next;
            if (state == MUL_BUSY) begin
                count <= count + MUL_CNT_W'(1);
            end else begin
                count <= '0;
            end
        end
    end

    // operand capture on the start cycle
    always_ff @(posedge clk) begin
        if ((state == MUL_IDLE) && start) begin
            a_q <= a;
            b_q <= b;
        end
    end

    // hi/lo land as the multu leaves E
    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (state == MUL_DONE) begin
            hi <= product[63:32];
            lo <= product[31:0];
        end
    end

endmodule

//--- verilog/mini_core.sv
`timescale 1ns/1ns

module mini_core import mini_core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      instr_valid,
    input  word_t     instr,
    output logic      stall,
    output logic      wb_valid,
    output reg_addr_t wb_addr,
    output word_t     wb_data
);

    // decode stage
    logic      d_valid;
    word_t     d_instr;
    op_t       d_op;
    reg_addr_t d_ra1;
    reg_addr_t d_ra2;
    reg_addr_t d_rdst;
    logic      d_regwrite;
    word_t     d_imm;
    word_t     d_rd1;
    word_t     d_rd2;
    word_t     d_srca;
    word_t     d_srcb;

    // execute stage
    logic      e_valid;
    logic      e_regwrite;
    op_t       e_op;
    reg_addr_t e_rdst;
    word_t     e_srca;
    word_t     e_srcb;
    word_t     e_imm;
    word_t     e_result;

    // writeback stage
    logic      w_valid;
    logic      w_regwrite;
    reg_addr_t w_rdst;
    word_t     w_data;
    logic      w_write;

    logic      mul_start;
    logic      mul_busy;
    word_t     hi;
    word_t     lo;

    fwd_if fwd_e ();
    fwd_if fwd_w ();

    // accept on valid while not stalled, D holds under stall
    always_ff @(posedge clk) begin
        if (reset) begin
            d_valid <= 1'b0;
        end else if (!stall) begin
            d_valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && instr_valid) begin
            d_instr <= instr;
        end
    end

    inst_decode u_decode (
        .instr    (d_instr),
        .op       (d_op),
        .ra1      (d_ra1),
        .ra2      (d_ra2),
        .rdst     (d_rdst),
        .regwrite (d_regwrite),
        .imm      (d_imm)
    );

    regfile u_regfile (
        .clk (clk),
        .reset (reset),
        .ra1 (d_ra1),
        .ra2 (d_ra2),
        .wa  (w_rdst),
        .we  (w_write),
        .wd  (w_data),
        .rd1 (d_rd1),
        .rd2 (d_rd2)
    );

    fwd_hazard u_fwd_hazard (
        .ra1      (d_ra1),
        .ra2      (d_ra2),
        .rd1      (d_rd1),
        .rd2      (d_rd2),
        .fwd_e    (fwd_e.dst),
        .fwd_w    (fwd_w.dst),
        .mul_busy (mul_busy),
        .srca     (d_srca),
        .srcb     (d_srcb),
        .stall    (stall)
    );

    // E holds on stall, bubbles in D turn into NOPs
    always_ff @(posedge clk) begin
        if (reset) begin
            e_valid    <= 1'b0;
            e_regwrite <= 1'b0;
            e_op       <= OP_NOP;
        end else if (!stall) begin
            e_valid    <= d_valid;
            e_regwrite <= d_valid && d_regwrite;
            e_op       <= d_valid ? d_op : OP_NOP;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            e_rdst <= d_rdst;
            e_srca <= d_srca;
            e_srcb <= d_srcb;
            e_imm  <= d_imm;
        end
    end

    always_comb begin
        case (e_op)
            OP_ADDU:  e_result = e_srca + e_srcb;
            OP_SUBU:  e_result = e_srca - e_srcb;
            OP_AND:   e_result = e_srca & e_srcb;
            OP_OR:    e_result = e_srca | e_srcb;
            OP_XOR:   e_result = e_srca ^ e_srcb;
            OP_SLT:   e_result = {31'b0, $signed(e_srca) < $signed(e_srcb)};
            OP_ADDIU: e_result = e_srca + e_imm;
            OP_LUI:   e_result = e_imm;
            OP_MFHI:  e_result = hi;
            OP_MFLO:  e_result = lo;
            default:  e_result = '0;
        endcase
    end

    // multiplier ignores start unless idle
    assign mul_start = e_valid && (e_op == OP_MULTU);

    mul_fsm u_mul_fsm (
        .clk   (clk),
        .reset (reset),
        .start (mul_start),
        .a     (e_srca),
        .b     (e_srcb),
        .busy  (mul_busy),
        .hi    (hi),
        .lo    (lo)
    );

    // W always advances, bubble while E is held
    always_ff @(posedge clk) begin
        if (reset) begin
            w_valid    <= 1'b0;
            w_regwrite <= 1'b0;
        end else begin
            w_valid    <= e_valid && !stall;
            w_regwrite <= e_regwrite && !stall;
        end
    end

    always_ff @(posedge clk) begin
        w_rdst <= e_rdst;
        w_data <= e_result;
    end

    assign fwd_e.rdst     = e_rdst;
    assign fwd_e.regwrite = e_regwrite && (e_rdst != '0);
    assign fwd_e.data     = e_result;
    assign fwd_e.valid    = e_valid;

    assign fwd_w.rdst     = w_rdst;
    assign fwd_w.regwrite = w_regwrite && (w_rdst != '0);
    assign fwd_w.data     = w_data;
    assign fwd_w.valid    = w_valid;

    assign w_write  = fwd_w.valid && fwd_w.regwrite;
    assign wb_valid = w_write;
    assign wb_addr  = w_rdst;
    assign wb_data  = w_data;

endmodule

//--- verif/mini_core_props.sv
`timescale 1ns/1ns

module mini_core_props import mini_core_pkg::*; (
    input logic       clk,
    input logic       reset,
    input logic       stall,
    input logic       wb_valid,
    input mul_state_t mul_state
);

    // length of the current stall run and busy run so far
    int stall_run;
    int busy_run;

    always_ff @(posedge clk) begin
        if (reset) begin
            stall_run <= 0;
            busy_run  <= 0;
        end else begin
            stall_run <= stall ? stall_run + 1 : 0;
            busy_run  <= (mul_state == MUL_BUSY) ? busy_run + 1 : 0;
        end
    end

    stall_low_in_reset: assert property (@(posedge clk) reset |=> !stall)
        else $error("stall high right after a reset cycle");

    stall_bounded: assert property (@(posedge clk) disable iff (reset)
        stall |-> stall_run < MUL_CYCLES + 1)
        else $error("stall held longer than one multiply");

    // W takes a bubble for every cycle that E is held
    wb_bubble_after_stall: assert property (@(posedge clk) disable iff (reset)
        stall |=> !wb_valid)
        else $error("writeback strobe in the cycle after a stall cycle");

    // first cycle out of MUL_BUSY still sees the full run length
    busy_length: assert property (@(posedge clk) disable iff (reset)
        (mul_state != MUL_BUSY) && (busy_run != 0) |-> busy_run == MUL_CYCLES)
        else $error("multiplier left busy after the wrong number of cycles");

endmodule

//--- verif/mini_core_tb.sv
`timescale 1ns/1ns

module mini_core_tb import mini_core_pkg::*; ();

    logic      clk;
    logic      reset;
    logic      instr_valid;
    word_t     instr;
    logic      stall;
    logic      wb_valid;
    reg_addr_t wb_addr;
    word_t     wb_data;

    // reference model state and the writes still to retire
    word_t       model_regs [32];
    word_t       model_hi;
    word_t       model_lo;
    logic [36:0] expected_q [$];
    logic [31:0] lcg_state = 32'd91;
    int          stall_cycles = 0;

    mini_core DUT (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .stall       (stall),
        .wb_valid    (wb_valid),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data)
    );

    bind mini_core mini_core_props u_props (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .wb_valid  (wb_valid),
        .mul_state (u_mul_fsm.state)
    );

    always #10 clk = ~clk;

    // upper half of the state since the low bits of an LCG repeat quickly
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {16'h0000, lcg_state[31:16]};
    endfunction

    function automatic word_t make_rtype(input logic [5:0] fn, input reg_addr_t rs,
                                         input reg_addr_t rt, input reg_addr_t rd);
        return {OPC_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t make_itype(input logic [5:0] opc, input reg_addr_t rs,
                                         input reg_addr_t rt, input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    // weighted draw over r0..r7 so that dependencies are frequent
    function automatic word_t random_instr();
        int          sel;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [15:0] imm;
        word_t       w;
        sel = int'(next_rand() % 32'd100);
        rs  = 5'(next_rand() % 32'd8);
        rt  = 5'(next_rand() % 32'd8);
        rd  = 5'(next_rand() % 32'd8);
        imm = 16'(next_rand());
        if (sel < 12) w = make_rtype(FN_ADDU, rs, rt, rd);
        else if (sel < 20) w = make_rtype(FN_SUBU, rs, rt, rd);
        else if (sel < 27) w = make_rtype(FN_AND, rs, rt, rd);
        else if (sel < 34) w = make_rtype(FN_OR, rs, rt, rd);
        else if (sel < 41) w = make_rtype(FN_XOR, rs, rt, rd);
        else if (sel < 50) w = make_rtype(FN_SLT, rs, rt, rd);
        else if (sel < 62) w = make_itype(OPC_ADDIU, rs, rt, imm);
        else if (sel < 70) w = make_itype(OPC_LUI, rs, rt, imm);
        else if (sel < 76) w = make_rtype(FN_MULTU, rs, rt, rd);
        else if (sel < 82) w = make_rtype(FN_MFHI, rs, rt, rd);
        else if (sel < 88) w = make_rtype(FN_MFLO, rs, rt, rd);
        // load word, sll and jr encodings fall outside the subset
        else if (sel < 92) w = make_itype(6'h23, rs, rt, imm);
        else if (sel < 96) w = make_rtype(6'h00, rs, rt, rd);
        else w = make_rtype(6'h08, rs, rt, rd);
        return w;
    endfunction

    function automatic void model_write(input reg_addr_t dst, input word_t val);
        if (dst != '0) begin
            model_regs[dst] = val;
            expected_q.push_back({dst, val});
        end
    endfunction

    function automatic void model_apply(input word_t w);
        word_t       a;
        word_t       b;
        word_t       simm;
        logic [63:0] prod;
        a    = model_regs[w[25:21]];
        b    = model_regs[w[20:16]];
        simm = {{16{w[15]}}, w[15:0]};
        if (w[31:26] == OPC_ADDIU) begin
            model_write(w[20:16], a + simm);
        end else if (w[31:26] == OPC_LUI) begin
            model_write(w[20:16], {w[15:0], 16'h0000});
        end else if (w[31:26] == OPC_SPECIAL) begin
            case (w[5:0])
                FN_ADDU: model_write(w[15:11], a + b);
                FN_SUBU: model_write(w[15:11], a - b);
                FN_AND:  model_write(w[15:11], a & b);
                FN_OR:   model_write(w[15:11], a | b);
                FN_XOR:  model_write(w[15:11], a ^ b);
                FN_SLT:  model_write(w[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                FN_MULTU: begin
                    prod     = {32'h0, a} * {32'h0, b};
                    model_hi = prod[63:32];
                    model_lo = prod[31:0];
                end
                FN_MFHI: model_write(w[15:11], model_hi);
                FN_MFLO: model_write(w[15:11], model_lo);
                default: begin
                end
            endcase
        end
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    // hold the word until taken with stall sampled mid-cycle
    task automatic issue(input word_t w);
        int waited;
        instr_valid <= 1'b1;
        instr       <= w;
        waited = 0;
        @(negedge clk);
        while (stall) begin
            waited++;
            if (waited > 2 * MUL_CYCLES + 4) begin
                fail_run("instruction still held by stall after the timeout");
            end else begin
                @(negedge clk);
            end
        end
        model_apply(w);
        @(posedge clk);
    endtask

    // junk on instr while instr_valid is low must be ignored
    task automatic idle(input int cycles);
        word_t junk;
        for (int i = 0; i < cycles; i++) begin
            junk = (next_rand() << 16) ^ next_rand();
            instr_valid <= 1'b0;
            instr       <= junk;
            @(posedge clk);
        end
    endtask

    // writebacks compared in retirement order
    always @(negedge clk) begin
        logic [36:0] entry;
        if (!reset) begin
            if (stall) begin
                stall_cycles++;
            end
            if (wb_valid) begin
                if (expected_q.size() == 0) begin
                    fail_run($sformatf("writeback to r%0d at %0t with no write expected",
                                       wb_addr, $time));
                end else begin
                    entry = expected_q.pop_front();
                    check_value("wb_addr", {27'd0, wb_addr}, {27'd0, entry[36:32]});
                    check_value("wb_data", wb_data, entry[31:0]);
                end
            end
        end
    end

    initial begin
        word_t w;
        int    n;
        clk         = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        model_hi    = '0;
        model_lo    = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        // file, hi and lo all zero out of reset
        issue(make_rtype(FN_ADDU, 5'd2, 5'd3, 5'd1));
        issue(make_rtype(FN_MFHI, 5'd0, 5'd0, 5'd4));
        issue(make_rtype(FN_MFLO, 5'd0, 5'd0, 5'd5));
        // dependent chain through E and W and a multiply read back at once
        issue(make_itype(OPC_LUI, 5'd0, 5'd1, 16'h8001));
        issue(make_itype(OPC_ADDIU, 5'd1, 5'd1, 16'hfffd));
        issue(make_itype(OPC_ADDIU, 5'd0, 5'd2, 16'h7fff));
        issue(make_rtype(FN_ADDU, 5'd1, 5'd2, 5'd3));
        issue(make_rtype(FN_MULTU, 5'd1, 5'd3, 5'd0));
        issue(make_rtype(FN_MFHI, 5'd0, 5'd0, 5'd6));
        issue(make_rtype(FN_MFLO, 5'd0, 5'd0, 5'd7));
        // r0 target and unknown encoding retire without a writeback
        issue(make_rtype(FN_XOR, 5'd1, 5'd2, 5'd0));
        issue(make_itype(6'h23, 5'd1, 5'd2, 16'h0010));
        issue(make_rtype(FN_SLT, 5'd1, 5'd0, 5'd4));

        for (n = 0; n < 500; n++) begin
            w = random_instr();
            issue(w);
            if (next_rand() % 32'd6 == 32'd0) begin
                idle(int'(next_rand() % 32'd3) + 1);
            end
        end
        instr_valid <= 1'b0;

        for (n = 0; n < 20 && expected_q.size() != 0; n++) begin
            @(posedge clk);
        end
        if (expected_q.size() != 0) begin
            fail_run($sformatf("%0d expected writebacks never arrived", expected_q.size()));
        end else if (stall_cycles == 0) begin
            fail_run("stall never rose during a multiply");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

//--- mini_core.f
verilog/mini_core_pkg.sv
verilog/fwd_if.sv
verilog/regfile.sv
verilog/inst_decode.sv
verilog/fwd_hazard.sv
verilog/mul_fsm.sv
verilog/mini_core.sv
verif/mini_core_props.sv
verif/mini_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then search the log for the pass line
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert -f mini_core.f \
        --top-module mini_core_tb -Mdir obj_dir -o mini_core_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/mini_core_sim > "$log" 2>&1; then
    cat "$log"
    echo "simulation exited with an error status"
    exit 1
fi
cat "$log"

if grep -q "TESTS PASSED" "$log"; then
    exit 0
fi
echo "pass line not found in $log"
exit 1
